// ==== ol_pkg.sv ====
package ol_pkg;

	// ------------------------------
	// bus and stream widths
	// ------------------------------
	// axi address and data
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	// one stream element
	localparam int BYTE_W = 8;
	// stream elements packed into one data word
	localparam int BYTES_PER_WORD = DATA_W / BYTE_W;
	// lane index inside a word
	localparam int LANE_W = $clog2(BYTES_PER_WORD);
	// layer, row and column counts
	localparam int DIM_W = 10;
	// axi burst length field
	localparam int LEN_W = 8;
	// address step of one beat
	localparam int BEAT_BYTES = DATA_W / 8;

	// ------------------------------
	// helpers
	// ------------------------------
	// words needed for one row, partial last word counts as one
	function automatic logic [DIM_W-1:0] words_per_row(input logic [DIM_W-1:0] cols);
		// full words plus one if any lanes left over
		return cols[DIM_W-1:LANE_W] + DIM_W'(|cols[LANE_W-1:0]);
	endfunction

endpackage

// ==== row_packer.sv ====
module row_packer
	import ol_pkg::*;
(
	input  logic              clk,
	input  logic              reset_n,
	input  logic              req,
	input  logic              ack,
	input  logic [DIM_W-1:0]  num_cols,
	input  logic [BYTE_W-1:0] in_data,
	input  logic              in_valid,
	input  logic              pk_ready,
	output logic              in_ready,
	output logic [DATA_W-1:0] pk_word,
	output logic              pk_last,
	output logic              pk_valid
);

	// position in the row: word index and lane inside it
	logic [LANE_W-1:0] lane;
	logic [DIM_W-1:0]  word_cnt;
	logic [DIM_W-1:0]  cols_m1;
	logic [DIM_W-1:0]  last_word_idx;
	// word under assembly, unwritten lanes stay zero
	logic [DATA_W-1:0] asm_word;
	logic [DATA_W-1:0] asm_next;
	logic              take;
	logic              last_col;
	logic              word_done;

	// ------------------------------
	// row position decode
	// ------------------------------
	assign cols_m1       = num_cols - 1'b1;
	assign last_word_idx = words_per_row(num_cols) - 1'b1;
	// last column = last word of the row and its final lane
	assign last_col = (word_cnt == last_word_idx) && (lane == cols_m1[LANE_W-1:0]);

	// stall while an output word is stuck, or outside an open job
	assign in_ready = req && !ack && !(pk_valid && !pk_ready);
	assign take     = in_valid && in_ready;
	// word closes on lane 7 or on the row's last byte
	assign word_done = take && (last_col || lane == LANE_W'(BYTES_PER_WORD - 1));

	// drop the incoming byte into its lane
	always_comb begin
		asm_next = asm_word;
		asm_next[lane*BYTE_W +: BYTE_W] = in_data;
	end

	// ------------------------------
	// lane and word counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n || !req) begin
			lane     <= '0;
			word_cnt <= '0;
		end else if (take) begin
			// lane restarts at every word boundary
			if (word_done) begin
				lane <= '0;
			end else begin
				lane <= lane + 1'b1;
			end
			// word index restarts at the row end
			if (last_col) begin
				word_cnt <= '0;
			end else if (word_done) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// assembly register, zeroed after each word for the padding
	always_ff @(posedge clk) begin
		if (!req) begin
			asm_word <= '0;
		end else if (take) begin
			asm_word <= word_done ? '0 : asm_next;
		end
	end

	// ------------------------------
	// output word
	// ------------------------------
	always_ff @(posedge clk) begin
		if (word_done) begin
			pk_word <= asm_next;
			pk_last <= last_col;
		end
	end

	// held until the buffer takes it
	always_ff @(posedge clk) begin
		if (!reset_n || !req) begin
			pk_valid <= 1'b0;
		end else if (word_done) begin
			pk_valid <= 1'b1;
		end else if (pk_ready) begin
			pk_valid <= 1'b0;
		end
	end

endmodule

// ==== word_fifo.sv ====
module word_fifo
	import ol_pkg::*;
#(
	parameter int FIFO_DEPTH = 16
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              req,
	input  logic [DATA_W-1:0] pk_word,
	input  logic              pk_last,
	input  logic              pk_valid,
	input  logic              buf_pop,
	output logic              pk_ready,
	output logic [DATA_W-1:0] buf_word,
	output logic              buf_last,
	output logic              buf_valid
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	// word storage plus row-end tag per entry
	logic [DATA_W-1:0] word_mem [FIFO_DEPTH];
	logic              last_mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              push;
	logic              pop;

	// ------------------------------
	// status and head entry
	// ------------------------------
	assign pk_ready  = (count != CNT_W'(FIFO_DEPTH));
	assign buf_valid = (count != '0);
	// first word falls through to the outputs
	assign buf_word  = word_mem[rd_ptr];
	assign buf_last  = last_mem[rd_ptr];

	assign push = pk_valid && pk_ready;
	assign pop  = buf_pop && buf_valid;

	// storage write, no reset on the array
	always_ff @(posedge clk) begin
		if (push) begin
			word_mem[wr_ptr] <= pk_word;
			last_mem[wr_ptr] <= pk_last;
		end
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	// flushed between jobs while req is low
	always_ff @(posedge clk) begin
		if (!reset_n || !req) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// wrap explicitly, depth need not be a power of two
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== burst_writer.sv ====
module burst_writer
	import ol_pkg::*;
#(
	parameter int LAYER_SHIFT = 12
) (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              req,
	input  logic [ADDR_W-1:0] base_addr,
	input  logic [DIM_W-1:0]  num_layers,
	input  logic [DIM_W-1:0]  num_rows,
	input  logic [DIM_W-1:0]  num_cols,
	input  logic [ADDR_W-1:0] row_stride,
	input  logic [DATA_W-1:0] buf_word,
	input  logic              buf_last,
	input  logic              buf_valid,
	input  logic              awready,
	input  logic              wready,
	input  logic              bvalid,
	output logic              buf_pop,
	output logic              ack,
	output logic [ADDR_W-1:0] awaddr,
	output logic [LEN_W-1:0]  awlen,
	output logic              awvalid,
	output logic [DATA_W-1:0] wdata,
	output logic              wlast,
	output logic              wvalid,
	output logic              bready
);

	// fsm encoding
	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ADDR = 3'd1;
	localparam logic [2:0] S_DATA = 3'd2;
	localparam logic [2:0] S_RESP = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;

	logic [2:0]        state;
	// progress through the job, layer is the inner loop
	logic [DIM_W-1:0]  layer_idx;
	logic [DIM_W-1:0]  row_idx;
	logic [ADDR_W-1:0] addr_next;
	logic              last_layer;
	logic              last_row;
	logic              b_done;
	logic              start_row;

	// ------------------------------
	// address and length
	// ------------------------------
	// base + layer stride + row offset, bursts start on a beat boundary
	assign addr_next = (base_addr + (ADDR_W'(layer_idx) << LAYER_SHIFT)
		+ ADDR_W'(row_idx) * row_stride) & ~ADDR_W'(BEAT_BYTES - 1);
	// whole row in one burst
	assign awlen = LEN_W'(words_per_row(num_cols) - 1'b1);

	assign last_layer = (layer_idx == num_layers - 1'b1);
	assign last_row   = (row_idx == num_rows - 1'b1);
	assign start_row  = (state == S_IDLE) && req && buf_valid;
	assign b_done     = (state == S_RESP) && bvalid;

	// ------------------------------
	// channel outputs from state
	// ------------------------------
	assign awvalid = (state == S_ADDR);
	// w channel follows the buffer head
	assign wvalid  = (state == S_DATA) && buf_valid;
	assign wdata   = buf_word;
	assign wlast   = wvalid && buf_last;
	assign buf_pop = wvalid && wready;
	assign bready  = (state == S_RESP);
	// held in done until req drops
	assign ack     = (state == S_DONE);

	// ------------------------------
	// fsm
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				// wait for the row's first word
				S_IDLE: if (start_row) state <= S_ADDR;
				S_ADDR: if (awready) state <= S_DATA;
				// tagged row end closes the burst
				S_DATA: if (buf_pop && buf_last) state <= S_RESP;
				S_RESP: begin
					if (bvalid) begin
						state <= (last_layer && last_row) ? S_DONE : S_IDLE;
					end
				end
				S_DONE: if (!req) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// captured on leaving idle, stable while awvalid
	always_ff @(posedge clk) begin
		if (start_row) begin
			awaddr <= addr_next;
		end
	end

	// ------------------------------
	// layer and row indices
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n || !req) begin
			layer_idx <= '0;
			row_idx   <= '0;
		end else if (b_done && !(last_layer && last_row)) begin
			// wrap the layer into the next row
			if (last_layer) begin
				layer_idx <= '0;
				row_idx   <= row_idx + 1'b1;
			end else begin
				layer_idx <= layer_idx + 1'b1;
			end
		end
	end

endmodule

// ==== output_layer_writer.sv ====
module output_layer_writer
	import ol_pkg::*;
#(
	parameter int FIFO_DEPTH  = 16,
	parameter int LAYER_SHIFT = 12
) (
	input  logic              clk,
	input  logic              reset_n,
	// host job control
	input  logic              req,
	input  logic [ADDR_W-1:0] base_addr,
	input  logic [DIM_W-1:0]  num_layers,
	input  logic [DIM_W-1:0]  num_rows,
	input  logic [DIM_W-1:0]  num_cols,
	input  logic [ADDR_W-1:0] row_stride,
	output logic              ack,
	// result byte stream
	input  logic [BYTE_W-1:0] in_data,
	input  logic              in_valid,
	output logic              in_ready,
	// axi write master
	output logic [ADDR_W-1:0] awaddr,
	output logic [LEN_W-1:0]  awlen,
	output logic              awvalid,
	input  logic              awready,
	output logic [DATA_W-1:0] wdata,
	output logic              wlast,
	output logic              wvalid,
	input  logic              wready,
	input  logic              bvalid,
	output logic              bready
);

	// packer to buffer
	logic [DATA_W-1:0] pk_word;
	logic              pk_last;
	logic              pk_valid;
	logic              pk_ready;
	// buffer to burst writer
	logic [DATA_W-1:0] buf_word;
	logic              buf_last;
	logic              buf_valid;
	logic              buf_pop;

	// ------------------------------
	// bytes into words
	// ------------------------------
	row_packer u_row_packer (
		.clk      (clk),
		.reset_n  (reset_n),
		.req      (req),
		.ack      (ack),
		.num_cols (num_cols),
		.in_data  (in_data),
		.in_valid (in_valid),
		.pk_ready (pk_ready),
		.in_ready (in_ready),
		.pk_word  (pk_word),
		.pk_last  (pk_last),
		.pk_valid (pk_valid)
	);

	word_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_word_fifo (
		.clk       (clk),
		.reset_n   (reset_n),
		.req       (req),
		.pk_word   (pk_word),
		.pk_last   (pk_last),
		.pk_valid  (pk_valid),
		.buf_pop   (buf_pop),
		.pk_ready  (pk_ready),
		.buf_word  (buf_word),
		.buf_last  (buf_last),
		.buf_valid (buf_valid)
	);

	// ------------------------------
	// words out as axi bursts
	// ------------------------------
	burst_writer #(
		.LAYER_SHIFT (LAYER_SHIFT)
	) u_burst_writer (
		.clk        (clk),
		.reset_n    (reset_n),
		.req        (req),
		.base_addr  (base_addr),
		.num_layers (num_layers),
		.num_rows   (num_rows),
		.num_cols   (num_cols),
		.row_stride (row_stride),
		.buf_word   (buf_word),
		.buf_last   (buf_last),
		.buf_valid  (buf_valid),
		.awready    (awready),
		.wready     (wready),
		.bvalid     (bvalid),
		.buf_pop    (buf_pop),
		.ack        (ack),
		.awaddr     (awaddr),
		.awlen      (awlen),
		.awvalid    (awvalid),
		.wdata      (wdata),
		.wlast      (wlast),
		.wvalid     (wvalid),
		.bready     (bready)
	);

endmodule

// ==== output_layer_properties.sv ====
module output_layer_properties
	import ol_pkg::*;
(
	input logic              clk,
	input logic              reset_n,
	input logic              req,
	input logic              ack,
	input logic              awvalid,
	input logic              awready,
	input logic [ADDR_W-1:0] awaddr,
	input logic              wvalid,
	input logic              wready,
	input logic [DATA_W-1:0] wdata,
	input logic              wlast
);

	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far
	int fail_cnt = 0;

	// ------------------------------
	// axi channel rules
	// ------------------------------
	// address held until the slave takes it
	aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			fail_cnt++;
			$error("awvalid dropped or awaddr changed before awready");
		end

	// write data held until the slave takes it
	w_hold: assert property (@(posedge clk) disable iff (!reset_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			fail_cnt++;
			$error("wvalid dropped or wdata changed before wready");
		end

	// no stray last flag
	wlast_valid: assert property (@(posedge clk) disable iff (!reset_n)
		wlast |-> wvalid)
		else begin
			fail_cnt++;
			$error("wlast high without wvalid");
		end

	// ------------------------------
	// req/ack handshake
	// ------------------------------
	ack_needs_req: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(ack) |-> req)
		else begin
			fail_cnt++;
			$error("ack rose while req was low");
		end

endmodule

// ==== tb_output_layer.sv ====
module tb_output_layer
	import ol_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 4;
	localparam int FIFO_DEPTH   = 16;
	localparam int LAYER_SHIFT  = 12;
	localparam logic [31:0] SEED = 32'd49;
	// cycles without progress before a wait gives up
	localparam int STALL_LIMIT  = 1000;
	localparam int ACK_LIMIT    = 20000;
	localparam int FALL_LIMIT   = 10;

	// ------------------------------
	// job table, one row per job
	// ------------------------------
	localparam int NJOBS = 5;
	int          job_layers [NJOBS] = '{1, 3, 3, 2, 2};
	int          job_rows   [NJOBS] = '{1, 4, 4, 3, 2};
	int          job_cols   [NJOBS] = '{8, 13, 13, 1, 24};
	logic [31:0] job_stride [NJOBS] = '{32'h40, 32'h20, 32'h20, 32'h8, 32'h40};
	logic [31:0] job_base   [NJOBS] = '{32'h1000_0000, 32'h2000_0000, 32'h2000_0100,
		32'h3000_0040, 32'h0000_8000};
	// random awready/wready stalls
	bit          job_stall  [NJOBS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

	logic clk = 1'b0;
	logic reset_n;
	logic req;
	logic [ADDR_W-1:0] base_addr;
	logic [DIM_W-1:0]  num_layers;
	logic [DIM_W-1:0]  num_rows;
	logic [DIM_W-1:0]  num_cols;
	logic [ADDR_W-1:0] row_stride;
	logic              ack;
	logic [BYTE_W-1:0] in_data;
	logic              in_valid;
	logic              in_ready;
	logic [ADDR_W-1:0] awaddr;
	logic [LEN_W-1:0]  awlen;
	logic              awvalid;
	logic              awready;
	logic [DATA_W-1:0] wdata;
	logic              wlast;
	logic              wvalid;
	logic              wready;
	logic              bvalid;
	logic              bready;

	// current job and its expected image
	int          cur_layers;
	int          cur_rows;
	int          cur_cols;
	int          cur_words;
	logic [31:0] cur_base;
	logic [31:0] cur_stride;
	bit          cur_stall;
	logic [7:0]  stream_q [$];
	logic [63:0] exp_mem [logic [31:0]];
	logic [63:0] mem [logic [31:0]];
	int          bursts_done;
	time         last_b_time;
	logic [31:0] lcg_state;
	int          err_cnt = 0;
	int          tmo_cnt = 0;
	int          chk_cnt = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	output_layer_writer #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.LAYER_SHIFT (LAYER_SHIFT)
	) u_output_layer_writer (
		.clk (clk), .reset_n (reset_n), .req (req), .base_addr (base_addr),
		.num_layers (num_layers), .num_rows (num_rows), .num_cols (num_cols),
		.row_stride (row_stride), .ack (ack), .in_data (in_data),
		.in_valid (in_valid), .in_ready (in_ready), .awaddr (awaddr),
		.awlen (awlen), .awvalid (awvalid), .awready (awready), .wdata (wdata),
		.wlast (wlast), .wvalid (wvalid), .wready (wready), .bvalid (bvalid),
		.bready (bready)
	);

	bind output_layer_writer output_layer_properties u_output_layer_properties (
		.clk (clk), .reset_n (reset_n), .req (req), .ack (ack),
		.awvalid (awvalid), .awready (awready), .awaddr (awaddr),
		.wvalid (wvalid), .wready (wready), .wdata (wdata), .wlast (wlast)
	);

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// true with roughly pct percent odds
	function automatic bit chance(int pct);
		int r;
		r = int'(lcg_next() >> 16);
		return (r % 100) < pct;
	endfunction

	// burst start: base, layer stride, row offset
	function automatic logic [31:0] row_addr(int row, int layer);
		return cur_base + (32'(layer) << LAYER_SHIFT) + 32'(row) * cur_stride;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expv);
		chk_cnt++;
		assert (got === expv) else begin
			err_cnt++;
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, expv);
		end
	endtask

	// stream bytes and expected words, row outer, layer inner, column innermost
	task automatic build_job(int j);
		logic [31:0] a;
		logic [31:0] r;
		cur_layers = job_layers[j];
		cur_rows   = job_rows[j];
		cur_cols   = job_cols[j];
		cur_words  = (cur_cols + 7) / 8;
		cur_base   = job_base[j];
		cur_stride = job_stride[j];
		cur_stall  = job_stall[j];
		stream_q.delete();
		exp_mem.delete();
		mem.delete();
		bursts_done = 0;
		for (int row = 0; row < cur_rows; row++) begin
			for (int lay = 0; lay < cur_layers; lay++) begin
				for (int c = 0; c < cur_cols; c++) begin
					r = lcg_next();
					stream_q.push_back(r[23:16]);
					a = row_addr(row, lay) + 32'((c / 8) * 8);
					// fresh words start zero, so padding lanes stay zero
					if (!exp_mem.exists(a)) begin
						exp_mem[a] = '0;
					end
					exp_mem[a][(c % 8) * 8 +: 8] = r[23:16];
				end
			end
		end
	endtask

	// ------------------------------
	// byte source
	// ------------------------------
	task automatic drive_stream();
		int idx;
		int idle;
		idx  = 0;
		idle = 0;
		while (idx < stream_q.size() && idle < STALL_LIMIT) begin
			@(posedge clk);
			if (in_valid && in_ready) begin
				idx++;
				idle = 0;
			end else begin
				idle++;
			end
			// random gaps in valid
			if (idx < stream_q.size() && chance(75)) begin
				in_valid <= 1'b1;
				in_data  <= stream_q[idx];
			end else begin
				in_valid <= 1'b0;
			end
		end
		in_valid <= 1'b0;
		if (idx < stream_q.size()) begin
			tmo_cnt++;
			$display("timeout: stream stuck after %0d of %0d bytes", idx, stream_q.size());
		end
	endtask

	// ------------------------------
	// axi slave and memory model
	// ------------------------------
	task automatic axi_respond();
		int phase;
		int beat;
		int idle;
		int total;
		logic [31:0] addr;
		total = cur_layers * cur_rows;
		phase = 0;
		beat  = 0;
		idle  = 0;
		addr  = '0;
		while (bursts_done < total && idle < STALL_LIMIT) begin
			@(posedge clk);
			idle++;
			case (phase)
				0: if (awvalid && awready) begin
					// layer index runs fastest
					check_value("awaddr", 64'(awaddr),
						64'(row_addr(bursts_done / cur_layers, bursts_done % cur_layers)));
					check_value("awlen", 64'(awlen), 64'(cur_words - 1));
					addr  = awaddr;
					beat  = 0;
					phase = 1;
					idle  = 0;
				end
				1: if (wvalid && wready) begin
					check_value("wlast", 64'(wlast), 64'(beat == cur_words - 1));
					assert (exp_mem.exists(addr)) else begin
						err_cnt++;
						$display("write to unexpected address %h at %0t", addr, $time);
					end
					mem[addr] = wdata;
					addr = addr + 32'd8;
					beat++;
					idle = 0;
					if (beat == cur_words) begin
						phase = 2;
						bvalid <= 1'b1;
					end
				end
				default: if (bvalid && bready) begin
					bvalid <= 1'b0;
					bursts_done++;
					last_b_time = $time;
					phase = 0;
					idle  = 0;
				end
			endcase
			awready <= (phase == 0) && (!cur_stall || chance(60));
			wready  <= (phase == 1) && (!cur_stall || chance(60));
		end
		awready <= 1'b0;
		wready  <= 1'b0;
		bvalid  <= 1'b0;
		if (bursts_done < total) begin
			tmo_cnt++;
			$display("timeout: only %0d of %0d bursts answered", bursts_done, total);
		end
	endtask

	// ------------------------------
	// req/ack handshake
	// ------------------------------
	task automatic wait_ack();
		int n;
		n = 0;
		while (!ack && n < ACK_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!ack) begin
			tmo_cnt++;
			$display("timeout: ack did not rise within %0d cycles", ACK_LIMIT);
		end else begin
			// all bursts answered, ack one cycle after the last response
			check_value("bursts before ack", 64'(bursts_done), 64'(cur_layers * cur_rows));
			check_value("ack delay after bresp", 64'($time - last_b_time), 64'(CLK_PERIOD));
		end
	endtask

	task automatic release_req();
		int n;
		n = 0;
		req <= 1'b0;
		do begin
			@(posedge clk);
			n++;
		end while (ack && n < FALL_LIMIT);
		if (ack) begin
			tmo_cnt++;
			$display("timeout: ack still high %0d cycles after req dropped", FALL_LIMIT);
		end else begin
			check_value("ack fall delay", 64'(n), 64'd2);
		end
		// ack stays low between jobs
		repeat (3) begin
			@(posedge clk);
			check_value("ack", 64'(ack), 64'd0);
		end
	endtask

	task automatic compare_image();
		foreach (exp_mem[a]) begin
			assert (mem.exists(a)) else begin
				err_cnt++;
				$display("word at address %h was never written", a);
			end
			if (mem.exists(a)) begin
				check_value($sformatf("mem[%h]", a), mem[a], exp_mem[a]);
			end
		end
	endtask

	task automatic run_job(int j);
		build_job(j);
		@(posedge clk);
		base_addr  <= cur_base;
		num_layers <= DIM_W'(cur_layers);
		num_rows   <= DIM_W'(cur_rows);
		num_cols   <= DIM_W'(cur_cols);
		row_stride <= cur_stride;
		req        <= 1'b1;
		fork
			drive_stream();
			axi_respond();
			wait_ack();
		join
		compare_image();
		release_req();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		lcg_state   = SEED;
		last_b_time = 0;
		reset_n    <= 1'b0;
		req        <= 1'b0;
		base_addr  <= '0;
		num_layers <= '0;
		num_rows   <= '0;
		num_cols   <= '0;
		row_stride <= '0;
		in_data    <= '0;
		in_valid   <= 1'b0;
		awready    <= 1'b0;
		wready     <= 1'b0;
		bvalid     <= 1'b0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		// quiet outputs out of reset
		check_value("ack", 64'(ack), 64'd0);
		check_value("in_ready", 64'(in_ready), 64'd0);
		check_value("awvalid", 64'(awvalid), 64'd0);
		check_value("wvalid", 64'(wvalid), 64'd0);
		check_value("bready", 64'(bready), 64'd0);
		for (int j = 0; j < NJOBS && tmo_cnt == 0; j++) begin
			run_job(j);
		end
		$display("checks %0d, value errors %0d, property failures %0d, timeouts %0d",
			chk_cnt, err_cnt, u_output_layer_writer.u_output_layer_properties.fail_cnt,
			tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0
			&& u_output_layer_writer.u_output_layer_properties.fail_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
ol_pkg.sv
row_packer.sv
word_fifo.sv
burst_writer.sv
output_layer_writer.sv
output_layer_properties.sv
tb_output_layer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line in the log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f sim.f --top-module tb_output_layer -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see sim.log"; exit 1; }
grep -q "^No errors$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
